/* common/core_types_pkg.sv */
`default_nettype none

package core_types_pkg;

    // datapath width, also used for PCs
    localparam int xlen = 32;

    // physical register tag width
    localparam int preg_idx_len = 6;

    // reorder buffer index width
    localparam int rob_idx_len = 5;

    typedef logic [xlen-1:0]         word_t;
    typedef logic [preg_idx_len-1:0] preg_idx_t;
    typedef logic [rob_idx_len-1:0]  rob_idx_t;

endpackage

`default_nettype wire

/* common/cdb_pkg.sv */
`default_nettype none

package cdb_pkg;

    // entries per completion queue and matching pointer width
    localparam int cdb_queue_depth   = 4;
    localparam int cdb_queue_idx_len = 2;

    // bit positions in the grant vector, highest priority first
    localparam int unit_count = 3;
    localparam int alu_unit   = 2;
    localparam int mul_unit   = 1;
    localparam int br_unit    = 0;

    // common result fields, 75 bits
    typedef struct packed {
        core_types_pkg::word_t     value;
        core_types_pkg::preg_idx_t dest_preg;
        core_types_pkg::rob_idx_t  rob_idx;
        core_types_pkg::word_t     pc;
    } fu_result_t;

    // branch resolution fields, 38 bits
    typedef struct packed {
        logic                  taken;
        core_types_pkg::word_t target_pc;
        logic                  mis_pred;
        logic                  cond_branch;
        logic                  uncond_branch;
        logic                  local_pred;
        logic                  global_pred;
    } br_info_t;

    typedef struct packed {
        fu_result_t result;
        br_info_t   br_info;
        logic       is_branch;
    } cdb_packet_t;

    // one-hot, alu in bit 2, mul in bit 1, branch in bit 0
    typedef logic [unit_count-1:0] unit_grant_t;

endpackage

`default_nettype wire

/* cdb/completion_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module completion_queue (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 push_valid,
    input  cdb_pkg::cdb_packet_t push_packet,
    input  logic                 pop,
    output logic                 ready,
    output logic                 head_valid,
    output cdb_pkg::cdb_packet_t head_packet
);

    import cdb_pkg::*;

    typedef logic [cdb_queue_idx_len-1:0] queue_ptr_t;
    typedef logic [cdb_queue_idx_len:0]   queue_count_t;

    cdb_packet_t  entries [cdb_queue_depth];
    queue_ptr_t   head_ptr;
    queue_ptr_t   tail_ptr;
    queue_count_t count;

    logic empty;
    logic push;
    logic store;
    logic release_head;

    assign empty = (count == '0);
    assign ready = (count < queue_count_t'(cdb_queue_depth));

    // accepted input is dropped while flushing
    assign push = push_valid && ready && !flush;

    // empty queue lets the incoming result through to the arbiter
    assign head_valid  = empty ? push_valid : 1'b1;
    assign head_packet = empty ? push_packet : entries[head_ptr];

    // a bypassed result that wins the bus is never written
    assign store        = push && !(empty && pop);
    assign release_head = pop && !empty;

    always_ff @(posedge clock) begin
        if (store) begin
            entries[tail_ptr] <= push_packet;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (store) begin
                tail_ptr <= tail_ptr + queue_ptr_t'(1);
            end
            if (release_head) begin
                head_ptr <= head_ptr + queue_ptr_t'(1);
            end
            case ({store, release_head})
                2'b10:   count <= count + queue_count_t'(1);
                2'b01:   count <= count - queue_count_t'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* cdb/cdb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
    input  logic [cdb_pkg::unit_count-1:0] head_valid,
    input  cdb_pkg::cdb_packet_t           alu_head,
    input  cdb_pkg::cdb_packet_t           mul_head,
    input  cdb_pkg::cdb_packet_t           br_head,
    output cdb_pkg::unit_grant_t           grant,
    output logic                           grant_valid,
    output cdb_pkg::cdb_packet_t           grant_packet
);

    import cdb_pkg::*;

    assign grant_valid = |head_valid;

    // fixed order alu, mul, branch
    always_comb begin
        grant        = '0;
        // branch head unless a higher unit wins
        grant_packet = br_head;
        if (head_valid[alu_unit]) begin
            grant[alu_unit] = 1'b1;
            grant_packet    = alu_head;
        end else if (head_valid[mul_unit]) begin
            grant[mul_unit] = 1'b1;
            grant_packet    = mul_head;
        end else if (head_valid[br_unit]) begin
            grant[br_unit] = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* cdb/cdb_broadcast.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_broadcast (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 flush,
    input  cdb_pkg::unit_grant_t grant,
    input  logic                 grant_valid,
    input  cdb_pkg::cdb_packet_t grant_packet,
    output cdb_pkg::unit_grant_t pop,
    output logic                 cdb_valid,
    output cdb_pkg::cdb_packet_t cdb_packet
);

    import cdb_pkg::*;

    // winner leaves its queue in the grant cycle
    assign pop = flush ? unit_grant_t'('0) : grant;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= grant_valid;
        end
    end

    // bus contents only change when something wins
    always_ff @(posedge clock) begin
        if (grant_valid) begin
            cdb_packet <= grant_packet;
        end
    end

endmodule

`default_nettype wire

/* cdb/cdb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_top (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 commit_mis_pred,
    input  logic                 alu_valid,
    input  logic                 mul_valid,
    input  logic                 br_valid,
    input  cdb_pkg::fu_result_t  alu_result,
    input  cdb_pkg::fu_result_t  mul_result,
    input  cdb_pkg::cdb_packet_t br_packet,
    output logic                 alu_ready,
    output logic                 mul_ready,
    output logic                 br_ready,
    output logic                 cdb_valid,
    output cdb_pkg::cdb_packet_t cdb_packet
);

    import cdb_pkg::*;

    cdb_packet_t           alu_packet;
    cdb_packet_t           mul_packet;
    cdb_packet_t           alu_head;
    cdb_packet_t           mul_head;
    cdb_packet_t           br_head;
    cdb_packet_t           grant_packet;
    logic [unit_count-1:0] head_valid;
    unit_grant_t           grant;
    unit_grant_t           pop;
    logic                  grant_valid;

    // non-branch units carry no resolution info
    assign alu_packet = '{result: alu_result, br_info: '0, is_branch: 1'b0};
    assign mul_packet = '{result: mul_result, br_info: '0, is_branch: 1'b0};

    completion_queue u_alu_queue (
        .clock       (clock),
        .reset       (reset),
        .flush       (commit_mis_pred),
        .push_valid  (alu_valid),
        .push_packet (alu_packet),
        .pop         (pop[alu_unit]),
        .ready       (alu_ready),
        .head_valid  (head_valid[alu_unit]),
        .head_packet (alu_head)
    );

    completion_queue u_mul_queue (
        .clock       (clock),
        .reset       (reset),
        .flush       (commit_mis_pred),
        .push_valid  (mul_valid),
        .push_packet (mul_packet),
        .pop         (pop[mul_unit]),
        .ready       (mul_ready),
        .head_valid  (head_valid[mul_unit]),
        .head_packet (mul_head)
    );

    completion_queue u_br_queue (
        .clock       (clock),
        .reset       (reset),
        .flush       (commit_mis_pred),
        .push_valid  (br_valid),
        .push_packet (br_packet),
        .pop         (pop[br_unit]),
        .ready       (br_ready),
        .head_valid  (head_valid[br_unit]),
        .head_packet (br_head)
    );

    cdb_arbiter u_arbiter (
        .head_valid   (head_valid),
        .alu_head     (alu_head),
        .mul_head     (mul_head),
        .br_head      (br_head),
        .grant        (grant),
        .grant_valid  (grant_valid),
        .grant_packet (grant_packet)
    );

    cdb_broadcast u_broadcast (
        .clock        (clock),
        .reset        (reset),
        .flush        (commit_mis_pred),
        .grant        (grant),
        .grant_valid  (grant_valid),
        .grant_packet (grant_packet),
        .pop          (pop),
        .cdb_valid    (cdb_valid),
        .cdb_packet   (cdb_packet)
    );

endmodule

`default_nettype wire

/* testbench/cdb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_checker (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 alu_valid,
    input  logic                 mul_valid,
    input  logic                 br_valid,
    input  cdb_pkg::fu_result_t  alu_result,
    input  cdb_pkg::fu_result_t  mul_result,
    input  cdb_pkg::cdb_packet_t br_packet,
    input  logic                 alu_ready,
    input  logic                 mul_ready,
    input  logic                 br_ready,
    input  logic [2:0]           expected_ready,
    input  logic                 cdb_valid,
    input  cdb_pkg::cdb_packet_t cdb_packet,
    output int                   error_count,
    output logic [2:0]           pending
);

    import cdb_pkg::*;

    // model of the three completion queues
    cdb_packet_t alu_q [$];
    cdb_packet_t mul_q [$];
    cdb_packet_t br_q [$];

    cdb_packet_t incoming;
    cdb_packet_t expected_packet;
    logic        expected_valid = 1'b0;
    logic        armed = 1'b0;
    int          errors = 0;
    logic [2:0]  pending_units = '0;
    // results accepted per unit and not yet seen on the bus
    int          outstanding [unit_count];
    int          expected_unit = 0;

    assign error_count = errors;
    assign pending     = pending_units;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected %h, got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_packet();
        check_value("cdb_packet.value", expected_packet.result.value, cdb_packet.result.value);
        check_value("cdb_packet.dest_preg", 32'(expected_packet.result.dest_preg),
                    32'(cdb_packet.result.dest_preg));
        check_value("cdb_packet.rob_idx", 32'(expected_packet.result.rob_idx),
                    32'(cdb_packet.result.rob_idx));
        check_value("cdb_packet.pc", expected_packet.result.pc, cdb_packet.result.pc);
        check_value("cdb_packet.taken", 32'(expected_packet.br_info.taken),
                    32'(cdb_packet.br_info.taken));
        check_value("cdb_packet.target_pc", expected_packet.br_info.target_pc,
                    cdb_packet.br_info.target_pc);
        check_value("cdb_packet.mis_pred", 32'(expected_packet.br_info.mis_pred),
                    32'(cdb_packet.br_info.mis_pred));
        check_value("cdb_packet.cond_branch", 32'(expected_packet.br_info.cond_branch),
                    32'(cdb_packet.br_info.cond_branch));
        check_value("cdb_packet.uncond_branch", 32'(expected_packet.br_info.uncond_branch),
                    32'(cdb_packet.br_info.uncond_branch));
        check_value("cdb_packet.local_pred", 32'(expected_packet.br_info.local_pred),
                    32'(cdb_packet.br_info.local_pred));
        check_value("cdb_packet.global_pred", 32'(expected_packet.br_info.global_pred),
                    32'(cdb_packet.br_info.global_pred));
        check_value("cdb_packet.is_branch", 32'(expected_packet.is_branch),
                    32'(cdb_packet.is_branch));
    endtask

    initial begin
        foreach (outstanding[u]) begin
            outstanding[u] = 0;
        end
    end

    // inputs and outputs are both settled at the falling edge
    always @(negedge clock) begin
        if (armed) begin
            check_value("alu_ready", 32'(expected_ready[2]), 32'(alu_ready));
            check_value("mul_ready", 32'(expected_ready[1]), 32'(mul_ready));
            check_value("br_ready", 32'(expected_ready[0]), 32'(br_ready));
            check_value("cdb_valid", 32'(expected_valid), 32'(cdb_valid));
            if (expected_valid && cdb_valid) begin
                compare_packet();
                outstanding[expected_unit]--;
            end
        end
        if (reset || flush) begin
            alu_q.delete();
            mul_q.delete();
            br_q.delete();
            foreach (outstanding[u]) begin
                outstanding[u] = 0;
            end
            expected_valid = 1'b0;
            armed = armed || reset;
        end else begin
            // pushes go first so an empty queue hands over its input at once
            if (alu_valid && alu_q.size() < cdb_queue_depth) begin
                incoming = '{result: alu_result, br_info: '0, is_branch: 1'b0};
                alu_q.push_back(incoming);
                outstanding[alu_unit]++;
            end
            if (mul_valid && mul_q.size() < cdb_queue_depth) begin
                incoming = '{result: mul_result, br_info: '0, is_branch: 1'b0};
                mul_q.push_back(incoming);
                outstanding[mul_unit]++;
            end
            if (br_valid && br_q.size() < cdb_queue_depth) begin
                br_q.push_back(br_packet);
                outstanding[br_unit]++;
            end
            expected_valid = 1'b1;
            if (alu_q.size() != 0) begin
                expected_packet = alu_q.pop_front();
                expected_unit   = alu_unit;
            end else if (mul_q.size() != 0) begin
                expected_packet = mul_q.pop_front();
                expected_unit   = mul_unit;
            end else if (br_q.size() != 0) begin
                expected_packet = br_q.pop_front();
                expected_unit   = br_unit;
            end else begin
                expected_valid = 1'b0;
            end
        end
        pending_units = {outstanding[alu_unit] != 0,
                         outstanding[mul_unit] != 0,
                         outstanding[br_unit] != 0};
    end

endmodule

`default_nettype wire

/* testbench/cdb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_tb;

    import core_types_pkg::*;
    import cdb_pkg::*;

    typedef struct packed {
        logic       alu_valid;
        logic       mul_valid;
        logic       br_valid;
        logic       flush;
        logic [2:0] ready;
    } stim_row_t;

    localparam int reset_cycles   = 5;
    localparam int row_count      = 26;
    localparam int timeout_cycles = reset_cycles + row_count + 3 * cdb_queue_depth + 20;

    // row bits are alu mul br valid, flush and expected ready for alu mul br
    localparam logic [6:0] stim_table [row_count] = '{
        7'b1000_111, 7'b0000_111,
        // all three at once
        7'b1110_111, 7'b0000_111, 7'b0000_111, 7'b0000_111,
        7'b0010_111, 7'b0000_111,
        // alu keeps the bus while mul fills up
        7'b1100_111, 7'b1100_111, 7'b1100_111, 7'b1100_111, 7'b1100_101,
        7'b0000_101, 7'b0000_111, 7'b0000_111, 7'b0000_111, 7'b0000_111,
        // flush with a full mul queue
        7'b1110_111, 7'b1100_111, 7'b1100_111, 7'b1100_111, 7'b1101_101,
        7'b0100_111, 7'b0000_111, 7'b0000_111
    };

    logic        clock;
    logic        reset;
    logic        commit_mis_pred;
    logic        alu_valid;
    logic        mul_valid;
    logic        br_valid;
    fu_result_t  alu_result;
    fu_result_t  mul_result;
    cdb_packet_t br_packet;
    logic        alu_ready;
    logic        mul_ready;
    logic        br_ready;
    logic        cdb_valid;
    cdb_packet_t cdb_packet;
    logic [2:0]  expected_ready;
    logic [2:0]  pending;
    int          error_count;
    int          cycle_count = 0;

    cdb_top u_dut (
        .clock           (clock),
        .reset           (reset),
        .commit_mis_pred (commit_mis_pred),
        .alu_valid       (alu_valid),
        .mul_valid       (mul_valid),
        .br_valid        (br_valid),
        .alu_result      (alu_result),
        .mul_result      (mul_result),
        .br_packet       (br_packet),
        .alu_ready       (alu_ready),
        .mul_ready       (mul_ready),
        .br_ready        (br_ready),
        .cdb_valid       (cdb_valid),
        .cdb_packet      (cdb_packet)
    );

    cdb_checker u_checker (
        .clock          (clock),
        .reset          (reset),
        .flush          (commit_mis_pred),
        .alu_valid      (alu_valid),
        .mul_valid      (mul_valid),
        .br_valid       (br_valid),
        .alu_result     (alu_result),
        .mul_result     (mul_result),
        .br_packet      (br_packet),
        .alu_ready      (alu_ready),
        .mul_ready      (mul_ready),
        .br_ready       (br_ready),
        .expected_ready (expected_ready),
        .cdb_valid      (cdb_valid),
        .cdb_packet     (cdb_packet),
        .error_count    (error_count),
        .pending        (pending)
    );

    function automatic fu_result_t random_result();
        fu_result_t r;
        r.value     = $urandom();
        r.dest_preg = preg_idx_t'($urandom());
        r.rob_idx   = rob_idx_t'($urandom());
        r.pc        = $urandom();
        return r;
    endfunction

    function automatic cdb_packet_t random_branch();
        cdb_packet_t p;
        logic [31:0] bits;
        bits                    = $urandom();
        p.result                = random_result();
        p.br_info.taken         = bits[0];
        p.br_info.target_pc     = $urandom();
        p.br_info.mis_pred      = bits[1];
        p.br_info.cond_branch   = bits[2];
        p.br_info.uncond_branch = bits[3];
        p.br_info.local_pred    = bits[4];
        p.br_info.global_pred   = bits[5];
        p.is_branch             = 1'b1;
        return p;
    endfunction

    task automatic apply_row(input logic [6:0] bits);
        stim_row_t row;
        row = stim_row_t'(bits);
        // producers hold off while their queue is full
        alu_valid       = row.alu_valid && alu_ready;
        mul_valid       = row.mul_valid && mul_ready;
        br_valid        = row.br_valid && br_ready;
        commit_mis_pred = row.flush;
        expected_ready  = row.ready;
        alu_result      = random_result();
        mul_result      = random_result();
        br_packet       = random_branch();
    endtask

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            if (pending[2]) $display("alu results never drained from their queue");
            if (pending[1]) $display("multiplier results never drained from their queue");
            if (pending[0]) $display("branch results never drained from their queue");
            $display("%0d errors, run stopped after %0d cycles without finishing",
                     error_count, cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h6086_debf));
        reset           = 1'b1;
        commit_mis_pred = 1'b0;
        alu_valid       = 1'b0;
        mul_valid       = 1'b0;
        br_valid        = 1'b0;
        alu_result      = random_result();
        mul_result      = random_result();
        br_packet       = random_branch();
        expected_ready  = 3'b111;
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int i = 0; i < row_count; i++) begin
            @(posedge clock);
            #1;
            apply_row(stim_table[i]);
        end
        @(posedge clock);
        #1;
        apply_row(7'b0000_111);
        while (pending != 3'b000 || cdb_valid) begin
            @(posedge clock);
            #1;
        end
        // let the checker see the last idle cycle
        @(negedge clock);
        #1;
        $display("%0d errors after %0d cycles", error_count, cycle_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
common/core_types_pkg.sv
common/cdb_pkg.sv
cdb/completion_queue.sv
cdb/cdb_arbiter.sv
cdb/cdb_broadcast.sv
cdb/cdb_top.sv
testbench/cdb_checker.sv
testbench/cdb_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --timescale 1ns/1ps --top-module cdb_tb -f src.f -o cdb_sim &&
    ./obj_dir/cdb_sim | tee /dev/stderr | grep -q "^Test completed successfully$" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
